// File: hw/bay_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "parking_defines.svh"

module bay_store (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  fee_tick,
    input  logic                  store_en,
    input  tower_pkg::bay_t       store_bay,
    input  car_pkg::plate_t       store_plate,
    input  logic                  remove_en,
    input  tower_pkg::bay_t       remove_bay,
    input  car_pkg::plate_t       lookup_plate,
    output logic                  lookup_hit,
    output tower_pkg::bay_t       lookup_bay,
    output logic                  free_found,
    output tower_pkg::bay_t       free_bay,
    output car_pkg::fee_t         removed_fee,
    output tower_pkg::bay_count_t empty_count
);

    import car_pkg::*;
    import tower_pkg::*;

    bay_mask_t  occupied;
    plate_t     plates  [`BAYS];
    car_class_t classes [`BAYS];
    fee_t       fees    [`BAYS];

    // Occupancy
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            occupied <= '0;
        end else begin
            if (store_en) begin
                occupied[store_bay] <= 1'b1;
            end
            if (remove_en) begin
                occupied[remove_bay] <= 1'b0;
            end
        end
    end

    // Per bay plate, class and fee accumulator
    for (genvar i = 0; i < `BAYS; i++) begin : g_bay
        logic            store_here;
        fee_t            rate;
        logic [`FEE_W:0] fee_sum;      // One extra bit to catch overflow

        assign store_here = store_en && (store_bay == bay_t'(i));

        always_comb begin
            case (classes[i])
                CAR_DISABLED: rate = fee_t'(0);
                CAR_HYBRID:   rate = fee_t'(1);
                default:      rate = fee_t'(2);
            endcase
        end

        assign fee_sum = {1'b0, fees[i]} + {1'b0, rate};

        always_ff @(posedge clock) begin
            if (store_here) begin
                plates[i]  <= store_plate;
                classes[i] <= plate_class(store_plate);
                fees[i]    <= '0;                       // New car starts free
            end else if (fee_tick && occupied[i]) begin
                fees[i] <= fee_sum[`FEE_W] ? '1 : fee_sum[`FEE_W-1:0];
            end
        end
    end

    // Lowest free bay, scanning down so the last hit wins
    always_comb begin
        free_found = 1'b0;
        free_bay   = '0;
        for (int i = `BAYS - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                free_found = 1'b1;
                free_bay   = bay_t'(i);
            end
        end
    end

    // Lowest occupied bay holding the plate
    always_comb begin
        lookup_hit = 1'b0;
        lookup_bay = '0;
        for (int i = `BAYS - 1; i >= 0; i--) begin
            if (occupied[i] && (plates[i] == lookup_plate)) begin
                lookup_hit = 1'b1;
                lookup_bay = bay_t'(i);
            end
        end
    end

    always_comb begin
        empty_count = '0;
        for (int i = 0; i < `BAYS; i++) begin
            empty_count = empty_count + bay_count_t'(!occupied[i]);
        end
    end

    assign removed_fee = fees[remove_bay];  // Read before the bay clears

    // The controller only stores into a bay that the free search offered
    store_into_occupied: assert property (
        @(posedge clock) disable iff (reset) store_en |-> !occupied[store_bay]
    ) else $error("bay_store: store into occupied bay %0d", store_bay);

endmodule

`default_nettype wire

// File: hw/car_pkg.sv
`default_nettype none

`include "parking_defines.svh"

package car_pkg;
    import tower_pkg::*;

    typedef logic [`PLATE_W-1:0] plate_t;
    typedef logic [`FEE_W-1:0]   fee_t;

    typedef enum logic [1:0] {
        CAR_DISABLED,
        CAR_HYBRID,
        CAR_REGULAR
    } car_class_t;

    typedef struct packed {
        logic   retrieve;       // 0 park, 1 retrieve
        plate_t plate;
    } order_t;

    typedef enum logic [1:0] {
        RECEIPT_PARKED,
        RECEIPT_DEPARTED,
        RECEIPT_FULL,
        RECEIPT_NOT_FOUND
    } receipt_kind_t;

    typedef struct packed {
        receipt_kind_t kind;
        plate_t        plate;
        bay_t          bay;     // Zero when no bay was touched
        fee_t          fee;     // Only set on departure
    } receipt_t;

    // Class comes from the top nibble of the plate
    function automatic car_class_t plate_class(plate_t plate);
        case (plate[`PLATE_W-1 -: 4])
            `CLASS_DISABLED: return CAR_DISABLED;
            `CLASS_HYBRID:   return CAR_HYBRID;
            default:         return CAR_REGULAR;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hw/elevator_controller.sv
`timescale 1ns/10ps
`default_nettype none

module elevator_controller (
    input  logic               clock,
    input  logic               reset,
    input  logic               order_valid,
    input  car_pkg::order_t    order_data,
    output logic               order_pop,
    input  logic               lookup_hit,
    input  tower_pkg::bay_t    lookup_bay,
    input  logic               free_found,
    input  tower_pkg::bay_t    free_bay,
    input  car_pkg::fee_t      removed_fee,
    output logic               store_en,
    output tower_pkg::bay_t    store_bay,
    output car_pkg::plate_t    store_plate,
    output logic               remove_en,
    output tower_pkg::bay_t    remove_bay,
    input  logic               receipt_ready,
    output logic               receipt_push,
    output car_pkg::receipt_t  receipt_data,
    output tower_pkg::floor_t  current_floor
);

    import car_pkg::*;
    import tower_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ASCEND,
        DESCEND,
        RECEIPT
    } state_t;

    state_t        state;
    order_t        order_q;         // Order being served
    bay_t          target_bay;
    receipt_kind_t kind_q;
    fee_t          fee_q;
    floor_t        target_floor;
    logic          at_target;
    logic          order_ok;        // Head order needs a trip

    assign target_floor = bay_floor(target_bay);
    assign at_target    = (current_floor == target_floor);
    assign order_ok     = order_data.retrieve ? lookup_hit : free_found;

    // Handshakes and bay access
    assign order_pop    = (state == IDLE) && order_valid;
    assign store_en     = (state == ASCEND) && at_target && !order_q.retrieve;
    assign remove_en    = (state == ASCEND) && at_target && order_q.retrieve;
    assign store_bay    = target_bay;
    assign remove_bay   = target_bay;
    assign store_plate  = order_q.plate;
    assign receipt_push = (state == RECEIPT) && receipt_ready;

    assign receipt_data = '{
        kind:  kind_q,
        plate: order_q.plate,
        bay:   target_bay,
        fee:   fee_q
    };

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= IDLE;
            current_floor <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (order_pop) begin
                        state <= order_ok ? ASCEND : RECEIPT;  // Full or unknown plate
                    end
                end
                ASCEND: begin
                    if (at_target) begin
                        state <= DESCEND;       // Bay access happens this cycle
                    end else begin
                        current_floor <= current_floor + 1'b1;
                    end
                end
                DESCEND: begin
                    current_floor <= current_floor - 1'b1;
                    if (current_floor == floor_t'(1)) begin
                        state <= RECEIPT;       // Back at the entrance
                    end
                end
                RECEIPT: begin
                    if (receipt_push) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Latched order and receipt contents
    always_ff @(posedge clock) begin
        if (order_pop) begin
            order_q <= order_data;
            fee_q   <= '0;
            if (order_data.retrieve) begin
                kind_q     <= lookup_hit ? RECEIPT_DEPARTED : RECEIPT_NOT_FOUND;
                target_bay <= lookup_hit ? lookup_bay : '0;
            end else begin
                kind_q     <= free_found ? RECEIPT_PARKED : RECEIPT_FULL;
                target_bay <= free_found ? free_bay : '0;
            end
        end
        if (remove_en) begin
            fee_q <= removed_fee;               // Fee of the departing car
        end
    end

    // Orders start and end at the entrance
    floor_at_entrance: assert property (
        @(posedge clock) disable iff (reset)
        ((state == IDLE) || (state == RECEIPT)) |-> (current_floor == '0)
    ) else $error("elevator_controller: waiting away from the entrance at floor %0d",
                  current_floor);

    // Never climbs past the target bay's floor
    floor_ceiling: assert property (
        @(posedge clock) disable iff (reset)
        (state == ASCEND) |-> (current_floor <= target_floor)
    ) else $error("elevator_controller: overshot floor %0d", target_floor);

endmodule

`default_nettype wire

// File: hw/order_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module order_fifo #(
    parameter int  DEPTH     = 8,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    output logic     push_ready,
    input  logic     pop,
    output logic     pop_valid,
    output payload_t pop_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;        // Occupancy, 0 to DEPTH

    // Wrap at DEPTH so depths other than a power of two work too
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    assign push_ready = (count != CNT_W'(DEPTH));
    assign pop_valid  = (count != '0);
    assign pop_data   = slots[rd_ptr];      // Head is visible without a pop

    // The producer must respect push_ready
    push_when_full: assert property (
        @(posedge clock) disable iff (reset) push |-> push_ready
    ) else $error("order_fifo: push while full");

    // The consumer must respect pop_valid
    pop_when_empty: assert property (
        @(posedge clock) disable iff (reset) pop |-> pop_valid
    ) else $error("order_fifo: pop while empty");

endmodule

`default_nettype wire

// File: hw/parking_defines.svh
`ifndef PARKING_DEFINES_SVH
`define PARKING_DEFINES_SVH

// Licence plate, the top nibble carries the class code
`define PLATE_W 16

// Building layout
`define FLOORS 7            // Parking floors above the entrance
`define BAYS   14           // Left and right bay on every floor

// Billing
`define FEE_W 8             // Saturates at all ones

// Queue depths
`define ORDER_DEPTH   8
`define RECEIPT_DEPTH 4

// Class nibbles, anything else is a regular car
`define CLASS_DISABLED 4'b1001
`define CLASS_HYBRID   4'b1000

`endif

// File: hw/parking_tower_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "parking_defines.svh"

module parking_tower_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  request_valid,
    input  logic                  request_retrieve,
    input  car_pkg::plate_t       request_plate,
    output logic                  request_ready,
    input  logic                  fee_tick,
    output logic                  result_valid,
    output car_pkg::receipt_t     result_data,
    input  logic                  result_ready,
    output tower_pkg::floor_t     current_floor,
    output tower_pkg::bay_count_t empty_count,
    output logic                  lot_full
);

    import car_pkg::*;
    import tower_pkg::*;

    order_t   request_order;
    logic     request_push;
    logic     order_valid;
    order_t   order_data;
    logic     order_pop;
    logic     lookup_hit;
    bay_t     lookup_bay;
    logic     free_found;
    bay_t     free_bay;
    fee_t     removed_fee;
    logic     store_en;
    bay_t     store_bay;
    plate_t   store_plate;
    logic     remove_en;
    bay_t     remove_bay;
    logic     receipt_ready;
    logic     receipt_push;
    receipt_t receipt_data;
    logic     result_pop;

    assign request_order = '{retrieve: request_retrieve, plate: request_plate};
    assign request_push  = request_valid && request_ready;   // Transfer on valid and ready
    assign result_pop    = result_valid && result_ready;
    assign lot_full      = (empty_count == '0);

    order_fifo #(
        .DEPTH     (`ORDER_DEPTH),
        .payload_t (order_t)
    ) order_queue (
        .clock      (clock),
        .reset      (reset),
        .push       (request_push),
        .push_data  (request_order),
        .push_ready (request_ready),
        .pop        (order_pop),
        .pop_valid  (order_valid),
        .pop_data   (order_data)
    );

    bay_store bay_store (
        .clock        (clock),
        .reset        (reset),
        .fee_tick     (fee_tick),
        .store_en     (store_en),
        .store_bay    (store_bay),
        .store_plate  (store_plate),
        .remove_en    (remove_en),
        .remove_bay   (remove_bay),
        .lookup_plate (order_data.plate),   // Plate of the order at the head
        .lookup_hit   (lookup_hit),
        .lookup_bay   (lookup_bay),
        .free_found   (free_found),
        .free_bay     (free_bay),
        .removed_fee  (removed_fee),
        .empty_count  (empty_count)
    );

    elevator_controller elevator_controller (
        .clock         (clock),
        .reset         (reset),
        .order_valid   (order_valid),
        .order_data    (order_data),
        .order_pop     (order_pop),
        .lookup_hit    (lookup_hit),
        .lookup_bay    (lookup_bay),
        .free_found    (free_found),
        .free_bay      (free_bay),
        .removed_fee   (removed_fee),
        .store_en      (store_en),
        .store_bay     (store_bay),
        .store_plate   (store_plate),
        .remove_en     (remove_en),
        .remove_bay    (remove_bay),
        .receipt_ready (receipt_ready),
        .receipt_push  (receipt_push),
        .receipt_data  (receipt_data),
        .current_floor (current_floor)
    );

    order_fifo #(
        .DEPTH     (`RECEIPT_DEPTH),
        .payload_t (receipt_t)
    ) receipt_queue (
        .clock      (clock),
        .reset      (reset),
        .push       (receipt_push),
        .push_data  (receipt_data),
        .push_ready (receipt_ready),
        .pop        (result_pop),
        .pop_valid  (result_valid),
        .pop_data   (result_data)
    );

endmodule

`default_nettype wire

// File: hw/tower_pkg.sv
`default_nettype none

`include "parking_defines.svh"

package tower_pkg;

    // Floor 0 is the entrance
    typedef logic [$clog2(`FLOORS + 1)-1:0] floor_t;

    // Bay index, even is left and odd is right
    typedef logic [$clog2(`BAYS)-1:0] bay_t;

    typedef logic [`BAYS-1:0] bay_mask_t;            // One bit per bay
    typedef logic [$clog2(`BAYS + 1)-1:0] bay_count_t;

    // Two bays per floor, starting on floor 1
    function automatic floor_t bay_floor(bay_t bay);
        return floor_t'(bay >> 1) + floor_t'(1);
    endfunction

endpackage

`default_nettype wire

// File: list.f
+incdir+hw
+incdir+sim
hw/tower_pkg.sv
hw/car_pkg.sv
hw/order_fifo.sv
hw/bay_store.sv
hw/elevator_controller.sv
hw/parking_tower_top.sv
sim/parking_tower_tb.sv

// File: sim/tower_model.svh
`ifndef TOWER_MODEL_SVH
`define TOWER_MODEL_SVH

// Expected bay contents, updated in the order requests are issued
localparam int FEE_MAX = (1 << `FEE_W) - 1;

logic   model_used  [`BAYS];
plate_t model_plate [`BAYS];
int     model_fee   [`BAYS];

// Billing rate from the class nibble
function automatic int class_rate(plate_t plate);
    case (plate[`PLATE_W-1 -: 4])
        `CLASS_DISABLED: return 0;
        `CLASS_HYBRID:   return 1;
        default:         return 2;
    endcase
endfunction

function automatic void model_clear();
    for (int i = 0; i < `BAYS; i++) begin
        model_used[i]  = 1'b0;
        model_plate[i] = '0;
        model_fee[i]   = 0;
    end
endfunction

// Serves one order and returns the receipt it should yield
function automatic receipt_t model_order(logic retrieve, plate_t plate);
    receipt_t r;
    logic     done;
    r.kind  = retrieve ? RECEIPT_NOT_FOUND : RECEIPT_FULL;
    r.plate = plate;
    r.bay   = '0;
    r.fee   = '0;
    done    = 1'b0;
    for (int i = 0; i < `BAYS; i++) begin      // Floor by floor, left first
        if (!done && retrieve && model_used[i] && (model_plate[i] == plate)) begin
            model_used[i] = 1'b0;
            r.kind        = RECEIPT_DEPARTED;
            r.bay         = bay_t'(i);
            r.fee         = fee_t'(model_fee[i]);
            done          = 1'b1;
        end else if (!done && !retrieve && !model_used[i]) begin
            model_used[i]  = 1'b1;
            model_plate[i] = plate;
            model_fee[i]   = 0;                  // Fresh car owes nothing
            r.kind         = RECEIPT_PARKED;
            r.bay          = bay_t'(i);
            done           = 1'b1;
        end
    end
    return r;
endfunction

// One billing tick on every occupied bay
function automatic void model_tick();
    for (int i = 0; i < `BAYS; i++) begin
        if (model_used[i]) begin
            model_fee[i] = model_fee[i] + class_rate(model_plate[i]);
            if (model_fee[i] > FEE_MAX) begin
                model_fee[i] = FEE_MAX;
            end
        end
    end
endfunction

function automatic bay_count_t model_empty();
    bay_count_t n;
    n = '0;
    for (int i = 0; i < `BAYS; i++) begin
        if (!model_used[i]) begin
            n = n + 1'b1;
        end
    end
    return n;
endfunction

`endif

// File: sim/parking_tower_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "parking_defines.svh"

module parking_tower_tb;

    import car_pkg::*;
    import tower_pkg::*;

    localparam int WAIT_LIMIT = 5000;       // Cycles before any wait gives up

    logic        clock;
    logic        reset;
    logic        request_valid;
    logic        request_retrieve;
    plate_t      request_plate;
    logic        request_ready;
    logic        fee_tick;
    logic        result_valid;
    receipt_t    result_data;
    logic        result_ready;
    floor_t      current_floor;
    bay_count_t  empty_count;
    logic        lot_full;

    integer      seed;
    logic        stall_mode;                // Random result_ready when set
    logic        saw_full;                  // request_ready seen low
    int          issued;
    int          received;
    logic [11:0] serial;                    // Keeps every plate unique
    receipt_t    expected [$];

    `include "tower_model.svh"

    parking_tower_top dut (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic report_failure(string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_receipt(receipt_t got, receipt_t want);
        if (got !== want) begin
            report_failure({$sformatf("MISMATCH at %0d ns: receipt %s %h bay %0d fee %0d",
                                      $time, got.kind.name(), got.plate, got.bay, got.fee),
                            $sformatf(", expected %s %h bay %0d fee %0d",
                                      want.kind.name(), want.plate, want.bay, want.fee)});
        end
    endtask

    task automatic check_count(bay_count_t got, bay_count_t want);
        if (got !== want) begin
            report_failure($sformatf("MISMATCH at %0d ns: empty_count %0d, expected %0d",
                                     $time, got, want));
        end
    endtask

    task automatic check_floor(floor_t got, floor_t want);
        if (got !== want) begin
            report_failure($sformatf("MISMATCH at %0d ns: current_floor %0d, expected %0d",
                                     $time, got, want));
        end
    endtask

    task automatic check_flag(logic got, logic want, string what);
        if (got !== want) begin
            report_failure($sformatf("MISMATCH at %0d ns: %s is %b, expected %b",
                                     $time, what, got, want));
        end
    endtask

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic plate_t fresh_plate(logic [3:0] nibble);
        serial = serial + 1'b1;
        return {nibble, serial};
    endfunction

    function automatic logic [3:0] random_class();
        case (rand_below(4))
            0:       return `CLASS_DISABLED;
            1:       return `CLASS_HYBRID;
            default: return 4'(rand_below(16));     // Mostly regular
        endcase
    endfunction

    // Next clock, then inputs change just after the edge
    task automatic step();
        @(posedge clock);
        #1;
        result_ready = stall_mode ? (rand_below(4) != 0) : 1'b1;
    endtask

    // Handshake happens on the edge after ready is seen high
    task automatic send(logic retrieve, plate_t plate);
        int waited;
        waited           = 0;
        request_valid    = 1'b1;
        request_retrieve = retrieve;
        request_plate    = plate;
        while (!request_ready) begin
            saw_full = 1'b1;
            step();
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("Timed out waiting for request_ready");
            end
        end
        expected.push_back(model_order(retrieve, plate));
        issued++;
        step();
        request_valid = 1'b0;
    endtask

    task automatic send_random();
        int bay;
        bay = rand_below(`BAYS);
        if (rand_below(2) == 1) begin
            if (model_used[bay]) begin
                send(1'b1, model_plate[bay]);
            end else begin
                send(1'b1, fresh_plate(4'h0));      // Nobody parked under it
            end
        end else begin
            send(1'b0, fresh_plate(random_class()));
        end
    endtask

    task automatic send_ticks(int n);
        for (int i = 0; i < n; i++) begin
            fee_tick = 1'b1;
            model_tick();
            step();
        end
        fee_tick = 1'b0;
    endtask

    // Waits for every receipt, then checks the idle outputs
    task automatic drain();
        int waited;
        waited = 0;
        while (received != issued) begin
            step();
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("Timed out waiting for outstanding receipts");
            end
        end
        check_count(empty_count, model_empty());
        check_flag(lot_full, model_empty() == '0, "lot_full");
        check_flag(request_ready, 1'b1, "request_ready");     // Order queue is empty
        check_flag(result_valid, 1'b0, "result_valid");       // No receipt left over
        check_floor(current_floor, '0);
    endtask

    // A transfer seen mid-cycle completes on the next rising edge
    initial begin
        forever begin
            @(negedge clock);
            if (!reset && result_valid && result_ready) begin
                if (expected.size() == 0) begin
                    report_failure("Got a receipt while no request was outstanding");
                end else begin
                    check_receipt(result_data, expected.pop_front());
                    received++;
                end
            end
        end
    end

    initial begin
        plate_t disabled_car;
        plate_t hybrid_car;
        plate_t regular_car;
        seed             = 53;
        reset            = 1'b1;
        request_valid    = 1'b0;
        request_retrieve = 1'b0;
        request_plate    = '0;
        fee_tick         = 1'b0;
        result_ready     = 1'b1;
        stall_mode       = 1'b0;
        saw_full         = 1'b0;
        issued           = 0;
        received         = 0;
        serial           = '0;
        model_clear();
        repeat (10) @(posedge clock);
        #1 reset = 1'b0;
        drain();

        // One car of each class, the regular fee runs into saturation
        disabled_car = fresh_plate(`CLASS_DISABLED);
        hybrid_car   = fresh_plate(`CLASS_HYBRID);
        regular_car  = fresh_plate(4'h3);
        send(1'b0, disabled_car);
        drain();
        send(1'b0, hybrid_car);
        drain();
        send(1'b0, regular_car);
        drain();
        send_ticks(40);
        send(1'b1, hybrid_car);
        drain();
        send_ticks(100);
        send(1'b1, regular_car);
        send(1'b1, disabled_car);
        drain();

        send(1'b1, fresh_plate(4'h5));          // Unknown plate
        drain();

        // Fifteenth car finds no room
        for (int i = 0; i < `BAYS + 1; i++) begin
            send(1'b0, fresh_plate(4'h2));
            drain();
        end

        // Bursts long enough to fill the order queue
        stall_mode = 1'b1;
        for (int round = 0; round < 20; round++) begin
            repeat (8 + rand_below(10)) begin
                send_random();
            end
            drain();
            send_ticks(rand_below(30));
        end

        if (!saw_full) begin
            report_failure("request_ready never dropped during a burst of requests");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
